//--- logic/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// timing counts in clk cycles
	localparam int CLK_PER_US = 10;
	localparam int CNT_W = 14;

	localparam logic [CNT_W-1:0] POWERUP_CYCLES   = CNT_W'(500 * CLK_PER_US);
	localparam logic [CNT_W-1:0] INIT_STEP_CYCLES = CNT_W'(10 * CLK_PER_US);  // e high per init cmd
	localparam logic [CNT_W-1:0] INIT_GAP0_CYCLES = CNT_W'(50 * CLK_PER_US);  // after function set
	localparam logic [CNT_W-1:0] INIT_GAP1_CYCLES = CNT_W'(50 * CLK_PER_US);  // after display ctrl
	localparam logic [CNT_W-1:0] INIT_GAP2_CYCLES = CNT_W'(200 * CLK_PER_US); // clear is slow
	localparam logic [CNT_W-1:0] INIT_GAP3_CYCLES = CNT_W'(100 * CLK_PER_US); // after entry mode
	localparam logic [CNT_W-1:0] WR_SETUP_CYCLES  = CNT_W'(1 * CLK_PER_US);
	localparam logic [CNT_W-1:0] WR_E_HIGH_CYCLES = CNT_W'(13 * CLK_PER_US);
	localparam logic [CNT_W-1:0] WR_TOTAL_CYCLES  = CNT_W'(50 * CLK_PER_US);

	// host register map
	localparam int REG_ADDR_W = 5;
	localparam logic [REG_ADDR_W-1:0] REG_MODE      = 5'd0;
	localparam logic [REG_ADDR_W-1:0] REG_CMD       = 5'd1;
	localparam logic [REG_ADDR_W-1:0] REG_LINE      = 5'd2;
	localparam logic [REG_ADDR_W-1:0] REG_STATUS    = 5'd3;  // {init_done, writer_busy, ctrl_busy}
	localparam logic [REG_ADDR_W-1:0] REG_CHAR_BASE = 5'd16;

	// mode bit order {lines, font, display, cursor, blink, inc_dec, shift}
	localparam logic [6:0] MODE_DEFAULT = 7'b1010010;

	localparam int LINE_CHARS = 16;
	localparam logic [7:0] LINE1_ADDR = 8'h40;

	typedef enum logic [7:0] {
		CMD_CLEAR        = 8'h01,
		CMD_ENTRY_MODE   = 8'h04,
		CMD_DISPLAY_CTRL = 8'h08,
		CMD_FUNCTION_SET = 8'h30,
		CMD_SET_DDRAM    = 8'h80
	} lcd_cmd_e;

	typedef enum logic [1:0] {
		CTRL_POWERUP,
		CTRL_INIT,
		CTRL_IDLE,
		CTRL_WRITE
	} ctrl_state_e;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_CHARS,
		WR_WAIT
	} writer_state_e;

endpackage

`default_nettype wire

//--- logic/lcd_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_config_regs
	import lcd_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  reg_we,
	input  wire logic [REG_ADDR_W-1:0] reg_addr,
	input  wire logic [7:0]            reg_wdata,
	output logic      [7:0]            reg_rdata,
	output logic      [6:0]            mode,
	output logic                       cmd_go,
	output logic      [7:0]            cmd_byte,
	output logic                       line_go,
	output logic                       line_sel,
	input  wire logic [3:0]            char_idx,
	output logic      [7:0]            char_data,
	input  wire logic                  ctrl_busy,
	input  wire logic                  writer_busy,
	input  wire logic                  init_done
);

	logic [7:0] char_buf [LINE_CHARS];
	logic       is_char;

	assign is_char = (reg_addr >= REG_CHAR_BASE);

	always_ff @(posedge clk) begin
		if (rst) begin
			mode     <= MODE_DEFAULT;
			cmd_go   <= 1'b0;
			line_go  <= 1'b0;
			line_sel <= 1'b0;
			for (int i = 0; i < LINE_CHARS; i++) begin
				char_buf[i] <= 8'h20;  // blank line
			end
		end else begin
			cmd_go  <= 1'b0;
			line_go <= 1'b0;
			if (reg_we && is_char) begin
				char_buf[reg_addr[3:0]] <= reg_wdata;
			end else if (reg_we) begin
				case (reg_addr)
					REG_MODE: mode <= reg_wdata[6:0];
					REG_CMD:  cmd_go <= 1'b1;
					REG_LINE: begin
						line_go  <= 1'b1;
						line_sel <= reg_wdata[0];
					end
					default: ;  // status is read only
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reg_we && reg_addr == REG_CMD) begin
			cmd_byte <= reg_wdata;
		end
	end

	assign char_data = char_buf[char_idx];

	always_comb begin
		reg_rdata = 8'h00;
		if (is_char) begin
			reg_rdata = char_buf[reg_addr[3:0]];
		end else begin
			case (reg_addr)
				REG_MODE:   reg_rdata = {1'b0, mode};
				REG_STATUS: reg_rdata = {5'b0, init_done, writer_busy, ctrl_busy};
				default:    reg_rdata = 8'h00;  // cmd and line are write only
			endcase
		end
	end

	a_go_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(cmd_go && line_go));
	a_go_single: assert property (@(posedge clk) disable iff (rst)
		(cmd_go || line_go) |=> !(cmd_go || line_go));

endmodule

`default_nettype wire

//--- logic/lcd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl
	import lcd_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic [6:0] mode,
	input  wire logic       req,
	input  wire logic       req_rs,
	input  wire logic [7:0] req_data,
	output logic            busy,
	output logic            init_done,
	output logic            e,
	output logic            rs,
	output logic            rw,
	output logic      [7:0] lcd_data
);

	ctrl_state_e      state;
	logic [CNT_W-1:0] cnt;
	logic [1:0]       init_step;

	// init command for a step with the mode bits merged in
	function automatic logic [7:0] init_byte(input logic [1:0] step, input logic [6:0] m);
		case (step)
			2'd0:    return CMD_FUNCTION_SET | {4'b0, m[6], m[5], 2'b00};
			2'd1:    return CMD_DISPLAY_CTRL | {5'b0, m[4:2]};
			2'd2:    return CMD_CLEAR;
			default: return CMD_ENTRY_MODE | {6'b0, m[1:0]};
		endcase
	endfunction

	function automatic logic [CNT_W-1:0] init_gap(input logic [1:0] step);
		case (step)
			2'd0:    return INIT_GAP0_CYCLES;
			2'd1:    return INIT_GAP1_CYCLES;
			2'd2:    return INIT_GAP2_CYCLES;
			default: return INIT_GAP3_CYCLES;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= CTRL_POWERUP;
			cnt       <= '0;
			init_step <= '0;
			busy      <= 1'b1;
			init_done <= 1'b0;
			e         <= 1'b0;
			rs        <= 1'b0;
			rw        <= 1'b0;
			lcd_data  <= 8'h00;
		end else begin
			rw <= 1'b0;  // write only bus
			case (state)
				CTRL_POWERUP: begin
					if (cnt == POWERUP_CYCLES - 1'b1) begin
						cnt       <= '0;
						init_step <= 2'd0;
						e         <= 1'b1;
						lcd_data  <= init_byte(2'd0, mode);
						state     <= CTRL_INIT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				CTRL_INIT: begin
					if (cnt == INIT_STEP_CYCLES - 1'b1) begin
						e        <= 1'b0;  // end of init pulse
						lcd_data <= 8'h00;
					end
					if (cnt == INIT_STEP_CYCLES + init_gap(init_step) - 1'b1) begin
						cnt <= '0;
						if (init_step == 2'd3) begin
							busy      <= 1'b0;
							init_done <= 1'b1;
							state     <= CTRL_IDLE;
						end else begin
							init_step <= init_step + 1'b1;
							e         <= 1'b1;
							lcd_data  <= init_byte(init_step + 1'b1, mode);
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				CTRL_IDLE: begin
					if (req) begin
						busy     <= 1'b1;
						rs       <= req_rs;
						lcd_data <= req_data;
						cnt      <= '0;
						state    <= CTRL_WRITE;
					end
				end
				CTRL_WRITE: begin
					if (cnt == WR_SETUP_CYCLES - 1'b1) begin
						e <= 1'b1;
					end
					if (cnt == WR_SETUP_CYCLES + WR_E_HIGH_CYCLES - 1'b1) begin
						e <= 1'b0;
					end
					if (cnt == WR_TOTAL_CYCLES - 1'b1) begin
						busy     <= 1'b0;
						rs       <= 1'b0;
						lcd_data <= 8'h00;
						cnt      <= '0;
						state    <= CTRL_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= CTRL_POWERUP;
			endcase
		end
	end

	a_write_holds: assert property (@(posedge clk) disable iff (rst)
		(state == CTRL_WRITE && cnt != WR_TOTAL_CYCLES - 1'b1) |=> (state == CTRL_WRITE && busy));
	a_e_needs_busy: assert property (@(posedge clk) disable iff (rst)
		$rose(e) |-> busy);
	a_data_stable: assert property (@(posedge clk) disable iff (rst)
		(e && $past(e)) |-> $stable(lcd_data));

endmodule

`default_nettype wire

//--- logic/lcd_text_writer.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_text_writer
	import lcd_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       cmd_go,
	input  wire logic [7:0] cmd_byte,
	input  wire logic       line_go,
	input  wire logic       line_sel,
	output logic      [3:0] char_idx,
	input  wire logic [7:0] char_data,
	output logic            req,
	output logic            req_rs,
	output logic      [7:0] req_data,
	input  wire logic       ctrl_busy,
	output logic            writer_busy
);

	writer_state_e state;
	logic          is_line;    // line write vs single raw command
	logic          seen_busy;  // ctrl took the request

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= WR_IDLE;
			writer_busy <= 1'b1;
			req         <= 1'b0;
			req_rs      <= 1'b0;
			char_idx    <= '0;
			is_line     <= 1'b0;
			seen_busy   <= 1'b0;
		end else begin
			req <= 1'b0;
			case (state)
				WR_IDLE: begin
					writer_busy <= 1'b0;
					if (!writer_busy && (cmd_go || line_go)) begin
						writer_busy <= 1'b1;
						is_line     <= line_go;
						char_idx    <= '0;
						req_data    <= line_go ? (CMD_SET_DDRAM | (line_sel ? LINE1_ADDR : 8'h00))
						                       : cmd_byte;
						state       <= WR_ADDR;
					end
				end
				WR_ADDR: begin
					if (!ctrl_busy) begin
						req       <= 1'b1;
						req_rs    <= 1'b0;  // command byte
						seen_busy <= 1'b0;
						state     <= WR_WAIT;
					end
				end
				WR_CHARS: begin
					if (!ctrl_busy) begin
						req       <= 1'b1;
						req_rs    <= 1'b1;  // data byte
						req_data  <= char_data;
						seen_busy <= 1'b0;
						state     <= WR_WAIT;
					end
				end
				WR_WAIT: begin
					if (ctrl_busy) begin
						seen_busy <= 1'b1;
					end else if (seen_busy) begin
						if (!is_line || (req_rs && char_idx == 4'(LINE_CHARS - 1))) begin
							writer_busy <= 1'b0;
							state       <= WR_IDLE;
						end else if (!req_rs) begin
							state <= WR_CHARS;  // chars follow the address
						end else begin
							char_idx <= char_idx + 1'b1;
							state    <= WR_CHARS;
						end
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	a_req_when_free: assert property (@(posedge clk) disable iff (rst)
		req |-> !ctrl_busy);

endmodule

`default_nettype wire

//--- logic/lcd_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_top
	import lcd_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  reg_we,
	input  wire logic [REG_ADDR_W-1:0] reg_addr,
	input  wire logic [7:0]            reg_wdata,
	output logic      [7:0]            reg_rdata,
	output logic                       e,
	output logic                       rs,
	output logic                       rw,
	output logic      [7:0]            lcd_data
);

	logic [6:0] mode;
	logic       cmd_go;
	logic [7:0] cmd_byte;
	logic       line_go;
	logic       line_sel;
	logic [3:0] char_idx;
	logic [7:0] char_data;
	logic       req;
	logic       req_rs;
	logic [7:0] req_data;
	logic       ctrl_busy;
	logic       writer_busy;
	logic       init_done;

	lcd_config_regs regs_i (
		.clk, .rst, .reg_we, .reg_addr, .reg_wdata, .reg_rdata,
		.mode, .cmd_go, .cmd_byte, .line_go, .line_sel,
		.char_idx, .char_data, .ctrl_busy, .writer_busy, .init_done
	);

	lcd_text_writer writer_i (
		.clk, .rst, .cmd_go, .cmd_byte, .line_go, .line_sel,
		.char_idx, .char_data, .req, .req_rs, .req_data,
		.ctrl_busy, .writer_busy
	);

	lcd_ctrl ctrl_i (
		.clk, .rst, .mode, .req, .req_rs, .req_data,
		.busy(ctrl_busy), .init_done, .e, .rs, .rw, .lcd_data
	);

endmodule

`default_nettype wire

//--- tests/lcd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_tb
	import lcd_pkg::*;
();

	localparam int HALF_PERIOD = 50;  // 100 ns clock
	localparam int WATCHDOG_CYCLES = int'(POWERUP_CYCLES) + 4 * int'(INIT_STEP_CYCLES)
		+ int'(INIT_GAP0_CYCLES) + int'(INIT_GAP1_CYCLES) + int'(INIT_GAP2_CYCLES)
		+ int'(INIT_GAP3_CYCLES) + 40 * int'(WR_TOTAL_CYCLES) + 2000;

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  reg_we;
	logic [REG_ADDR_W-1:0] reg_addr;
	logic [7:0]            reg_wdata;
	logic [7:0]            reg_rdata;
	logic                  e;
	logic                  rs;
	logic                  rw;
	logic [7:0]            lcd_data;

	int         value_errs = 0;
	int         other_errs = 0;
	logic [7:0] lfsr_state = 8'd56;

	logic             e_q;
	logic [CNT_W-1:0] hi_len;     // cycles e has been high so far
	logic [CNT_W-1:0] since_rst;
	int               pulse_cnt;
	logic [8:0]       obs_bytes [$];  // {rs, data} per e pulse
	logic [8:0]       exp_bytes [64];
	int               exp_cnt = 0;
	logic [8:0]       exp_head;
	logic             exp_known;

	assign exp_head  = exp_bytes[pulse_cnt[5:0]];
	assign exp_known = (pulse_cnt < exp_cnt);

	lcd_top dut_i (
		.clk, .rst, .reg_we, .reg_addr, .reg_wdata, .reg_rdata,
		.e, .rs, .rw, .lcd_data
	);

	always #HALF_PERIOD clk = ~clk;

	// LCD bus monitor
	always @(posedge clk) begin
		if (rst) begin
			e_q       <= 1'b0;
			hi_len    <= '0;
			since_rst <= '0;
			pulse_cnt <= 0;
		end else begin
			e_q       <= e;
			since_rst <= since_rst + 1'b1;
			hi_len    <= e ? hi_len + 1'b1 : '0;
			if (e && !e_q) begin
				obs_bytes.push_back({rs, lcd_data});
				pulse_cnt <= pulse_cnt + 1;
			end
		end
	end

	a_powerup_wait: assert property (@(posedge clk) disable iff (rst)
		($rose(e) && pulse_cnt == 0) |-> since_rst == POWERUP_CYCLES)
		else begin
			value_errs++;
			$display("ERR %0t: first e pulse after %0d cycles", $time, $sampled(since_rst));
		end
	a_pulse_expected: assert property (@(posedge clk) disable iff (rst)
		$rose(e) |-> exp_known)
		else begin
			other_errs++;
			$display("an e pulse appeared on the LCD bus that no test asked for");
		end
	a_byte_match: assert property (@(posedge clk) disable iff (rst)
		($rose(e) && exp_known) |-> ({rs, lcd_data} == exp_head))
		else begin
			value_errs++;
			$display("ERR %0t: bus rs/data %h, expected %h", $time, {rs, lcd_data},
				$sampled(exp_head));
		end
	a_pulse_width: assert property (@(posedge clk) disable iff (rst)
		$fell(e) |-> hi_len == ((pulse_cnt <= 4) ? INIT_STEP_CYCLES : WR_E_HIGH_CYCLES))
		else begin
			value_errs++;
			$display("ERR %0t: e pulse lasted %0d cycles", $time, $sampled(hi_len));
		end
	a_bus_stable: assert property (@(posedge clk) disable iff (rst)
		(e && $past(e)) |-> ($stable(lcd_data) && $stable(rs)))
		else begin
			value_errs++;
			$display("ERR %0t: rs or data moved while e was high", $time);
		end
	a_rw_low: assert property (@(posedge clk) disable iff (rst) !rw)
		else begin
			value_errs++;
			$display("ERR %0t: rw went high", $time);
		end

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic draw_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[6:0], lfsr_state[0]};
		end
	endtask

	// HD44780 command bytes built from the mode bits
	function automatic logic [7:0] function_set_of(input logic [6:0] m);
		return CMD_FUNCTION_SET | (8'(m[6]) << 3) | (8'(m[5]) << 2);  // N, F
	endfunction

	function automatic logic [7:0] display_ctrl_of(input logic [6:0] m);
		return CMD_DISPLAY_CTRL | 8'(m[4:2]);  // D, C, B
	endfunction

	function automatic logic [7:0] entry_mode_of(input logic [6:0] m);
		return CMD_ENTRY_MODE | 8'(m[1:0]);  // I/D, S
	endfunction

	task automatic expect_byte(input logic rs_v, input logic [7:0] d);
		exp_bytes[exp_cnt[5:0]] = {rs_v, d};
		exp_cnt++;
	endtask

	task automatic host_write(input logic [REG_ADDR_W-1:0] addr, input logic [7:0] data);
		@(posedge clk);
		reg_we    <= 1'b1;
		reg_addr  <= addr;
		reg_wdata <= data;
		@(posedge clk);
		reg_we <= 1'b0;
	endtask

	task automatic read_check(input logic [REG_ADDR_W-1:0] addr, input logic [7:0] mask,
		input logic [7:0] expv, input string what);
		@(posedge clk);
		reg_addr <= addr;
		@(negedge clk);
		a_read: assert ((reg_rdata & mask) == expv) else begin
			value_errs++;
			$display("ERR %0t: %s read %h, expected %h", $time, what, reg_rdata, expv);
		end
	endtask

	task automatic wait_status(input logic [7:0] mask, input logic [7:0] value);
		@(posedge clk);
		reg_addr <= REG_STATUS;
		@(negedge clk);
		while ((reg_rdata & mask) != value) @(negedge clk);
	endtask

	task automatic print_summary();
		$display("errors: %0d value, %0d other", value_errs, other_errs);
	endtask

	initial begin
		logic [7:0] chars [LINE_CHARS];
		logic [7:0] v;
		logic [6:0] new_mode;

		rst       <= 1'b1;
		reg_we    <= 1'b0;
		reg_addr  <= '0;
		reg_wdata <= '0;
		expect_byte(1'b0, function_set_of(MODE_DEFAULT));
		expect_byte(1'b0, display_ctrl_of(MODE_DEFAULT));
		expect_byte(1'b0, CMD_CLEAR);
		expect_byte(1'b0, entry_mode_of(MODE_DEFAULT));
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		read_check(REG_STATUS, 8'h05, 8'h01, "status in power-up");  // ctrl busy and init not done
		read_check(REG_MODE, 8'hff, {1'b0, MODE_DEFAULT}, "mode after reset");
		wait_status(8'h07, 8'h04);

		for (int i = 0; i < LINE_CHARS; i++) begin
			draw_bits(7, v);
			chars[i] = 8'h20 + 8'(v % 95);  // printable only
			host_write(REG_CHAR_BASE + 5'(i), chars[i]);
		end
		for (int i = 0; i < LINE_CHARS; i++) begin
			read_check(REG_CHAR_BASE + 5'(i), 8'hff, chars[i], "character buffer");
		end

		draw_bits(8, v);
		expect_byte(1'b0, v);
		host_write(REG_CMD, v);
		wait_status(8'h01, 8'h01);
		read_check(REG_STATUS, 8'hff, 8'h07, "status during write");
		wait_status(8'h07, 8'h04);

		expect_byte(1'b0, CMD_SET_DDRAM | LINE1_ADDR);
		for (int i = 0; i < LINE_CHARS; i++) begin
			expect_byte(1'b1, chars[i]);
		end
		host_write(REG_LINE, 8'h01);
		wait_status(8'h02, 8'h02);
		host_write(REG_LINE, 8'h00);  // dropped while the writer is busy
		wait_status(8'h07, 8'h04);

		draw_bits(7, v);
		new_mode = v[6:0];
		host_write(REG_MODE, {1'b0, new_mode});
		read_check(REG_MODE, 8'hff, {1'b0, new_mode}, "mode after write");
		expect_byte(1'b0, display_ctrl_of(new_mode));
		host_write(REG_CMD, display_ctrl_of(new_mode));
		wait_status(8'h01, 8'h01);
		wait_status(8'h07, 8'h04);

		repeat (4) @(posedge clk);
		a_pulse_count: assert (obs_bytes.size() == exp_cnt) else begin
			other_errs++;
			$display("saw %0d e pulses on the LCD bus instead of %0d", obs_bytes.size(), exp_cnt);
		end
		print_summary();
		if (value_errs == 0 && other_errs == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		other_errs++;
		$display("watchdog expired before the test sequence finished");
		print_summary();
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- lcd_display.f
logic/lcd_pkg.sv
logic/lcd_config_regs.sv
logic/lcd_ctrl.sv
logic/lcd_text_writer.sv
logic/lcd_top.sv
tests/lcd_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the LCD testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f lcd_display.f --top-module lcd_tb -Mdir obj_dir -o lcd_sim \
	&& ./obj_dir/lcd_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0
